// ==== rtl/looper_pkg.sv ====
package looper_pkg;

    // sample memory geometry
    localparam int ADDR_W          = 23;
    localparam int NUM_SLOTS       = 16;
    localparam int SLOT_W          = 4;
    localparam int PADS_PER_PAGE   = 8;
    // log2 of slot size in words, base = slot << shift
    localparam int DEF_CHUNK_SHIFT = 18;

    // operating mode, 4 bit wide on the panel output
    typedef enum logic [3:0] {
        IDLE = 4'd0,
        REC  = 4'd1,
        PLAY = 4'd2,
        MIX  = 4'd3
    } mode_e;

    // front panel button levels
    typedef struct packed {
        logic rec;
        logic play;
        logic mix;
        logic stop;
    } buttons_t;

    // slot index with valid flag
    // shared by record switch, play pad and backing slot
    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] idx;
    } slot_sel_t;

    // slide switch fields
    typedef struct packed {
        logic [1:0]           speed;
        logic [NUM_SLOTS-1:0] loop_mask;
    } knobs_t;

    // play engine command
    typedef struct packed {
        logic              start;
        logic              stop;
        logic [ADDR_W-1:0] addr;
        logic              backing;
        logic [ADDR_W-1:0] backing_addr;
        logic [1:0]        speed;
    } play_cmd_t;

    // record engine command
    typedef struct packed {
        logic              start;
        logic              stop;
        logic [ADDR_W-1:0] addr;
    } rec_cmd_t;

    // mix engine command, num bit 16 is the backing track
    typedef struct packed {
        logic                 start;
        logic                 stop;
        logic [NUM_SLOTS:0]   num;
        logic [ADDR_W-1:0]    backing_addr;
        logic [NUM_SLOTS-1:0] loop;
    } mix_cmd_t;

endpackage

// ==== rtl/panel_decoder.sv ====
`timescale 1ns/1ps

module panel_decoder (
    input  logic [13:0]            gpio,
    input  logic [17:0]            sw,
    output looper_pkg::buttons_t   buttons,
    output looper_pkg::slot_sel_t  pad,
    output looper_pkg::slot_sel_t  rec_sel,
    output looper_pkg::knobs_t     knobs
);

    // pad row as seen by the user, gpio 13 is the top pad
    logic [looper_pkg::PADS_PER_PAGE-1:0] pad_row;

    // exactly-one check plus index of the set bit
    // narrower rows are zero extended by the caller
    function automatic looper_pkg::slot_sel_t onehot_decode(
        input logic [looper_pkg::NUM_SLOTS-1:0] bits
    );
        looper_pkg::slot_sel_t       res;
        int unsigned                 ones;
        logic [looper_pkg::SLOT_W-1:0] pos;
        ones = 0;
        pos  = '0;
        for (int i = 0; i < looper_pkg::NUM_SLOTS; i++) begin
            if (bits[i]) begin
                ones = ones + 1;
                pos  = looper_pkg::SLOT_W'(i);
            end
        end
        // no bit or several bits gives an invalid selection
        res.valid = (ones == 1);
        res.idx   = res.valid ? pos : '0;
        return res;
    endfunction

    // buttons sit on gpio 11 down to 8
    always_comb begin
        buttons.rec  = gpio[11];
        buttons.play = gpio[10];
        buttons.mix  = gpio[9];
        buttons.stop = gpio[8];
    end

    assign pad_row = {gpio[13], gpio[6:0]};

    // pad index 0..7, page bit is added later
    assign pad = onehot_decode({{(looper_pkg::NUM_SLOTS - looper_pkg::PADS_PER_PAGE){1'b0}},
                                pad_row});

    // one raised record switch picks the slot
    assign rec_sel = onehot_decode(sw[15:0]);

    // speed overlaps the top loop switch on purpose
    always_comb begin
        knobs.speed     = sw[16:15];
        knobs.loop_mask = sw[15:0];
    end

endmodule

// ==== rtl/mode_controller.sv ====
`timescale 1ns/1ps

module mode_controller (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  looper_pkg::buttons_t  buttons,
    input  looper_pkg::slot_sel_t rec_sel,
    input  logic                  rec_done,
    input  logic                  play_done,
    input  logic                  mix_done,
    output looper_pkg::mode_e     mode,
    output logic                  page,
    output looper_pkg::slot_sel_t backing
);

    looper_pkg::mode_e     mode_n;
    logic                  page_n;
    looper_pkg::slot_sel_t backing_n;

    // state registers
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            mode    <= looper_pkg::IDLE;
            page    <= 1'b0;
            backing <= '0;
        end else begin
            mode    <= mode_n;
            page    <= page_n;
            backing <= backing_n;
        end
    end

    // next state
    always_comb begin
        mode_n    = mode;
        page_n    = page;
        backing_n = backing;
        case (mode)
            looper_pkg::IDLE: begin
                // mix wins over play, play over record
                if (buttons.mix) begin
                    mode_n = looper_pkg::MIX;
                end else if (buttons.play) begin
                    mode_n = looper_pkg::PLAY;
                end else if (buttons.rec) begin
                    mode_n = looper_pkg::REC;
                end
                // backing tracks the switches every idle cycle
                // invalid switch pattern clears it
                if (rec_sel.valid) begin
                    backing_n = rec_sel;
                end else begin
                    backing_n = '0;
                end
            end
            looper_pkg::REC: begin
                if (rec_done) begin
                    mode_n = looper_pkg::IDLE;
                end
            end
            looper_pkg::PLAY: begin
                if (play_done) begin
                    mode_n = looper_pkg::IDLE;
                end
                // record button doubles as page flip here
                if (buttons.rec) begin
                    page_n = ~page;
                end
            end
            looper_pkg::MIX: begin
                if (mix_done) begin
                    mode_n = looper_pkg::IDLE;
                end
                if (buttons.rec) begin
                    page_n = ~page;
                end
            end
            default: begin
                // unused encodings fall back to idle
                mode_n = looper_pkg::IDLE;
            end
        endcase
    end

endmodule

// ==== rtl/command_builder.sv ====
`timescale 1ns/1ps

module command_builder #(
    parameter int CHUNK_SHIFT = looper_pkg::DEF_CHUNK_SHIFT
) (
    input  looper_pkg::mode_e     mode,
    input  logic                  page,
    input  looper_pkg::slot_sel_t backing,
    input  looper_pkg::buttons_t  buttons,
    input  looper_pkg::slot_sel_t pad,
    input  looper_pkg::slot_sel_t rec_sel,
    input  looper_pkg::knobs_t    knobs,
    output looper_pkg::rec_cmd_t  rec_cmd,
    output looper_pkg::play_cmd_t play_cmd,
    output looper_pkg::mix_cmd_t  mix_cmd
);

    // page bit on top of the pad index
    logic [looper_pkg::SLOT_W-1:0]   pad_slot;
    // pad usable, i.e. valid and not the backing slot
    logic                            pad_hit;
    logic [looper_pkg::ADDR_W-1:0]   pad_addr;
    logic [looper_pkg::ADDR_W-1:0]   rec_addr;
    logic [looper_pkg::ADDR_W-1:0]   backing_addr;
    // one-hot of the pad slot, before suppression
    logic [looper_pkg::NUM_SLOTS-1:0] pad_mask;

    // base address of a slot in sample memory
    function automatic logic [looper_pkg::ADDR_W-1:0] slot_base(
        input logic [looper_pkg::SLOT_W-1:0] slot
    );
        return looper_pkg::ADDR_W'(slot) << CHUNK_SHIFT;
    endfunction

    assign pad_slot = {page, pad.idx[looper_pkg::SLOT_W-2:0]};

    // suppress only when backing is valid and on the same slot
    assign pad_hit = pad.valid && !(backing.valid && (backing.idx == pad_slot));

    // addresses are zero when their selection is not valid
    assign pad_addr     = pad.valid ? slot_base(pad_slot) : '0;
    assign rec_addr     = rec_sel.valid ? slot_base(rec_sel.idx) : '0;
    assign backing_addr = backing.valid ? slot_base(backing.idx) : '0;

    always_comb begin
        pad_mask           = '0;
        pad_mask[pad_slot] = 1'b1;
    end

    // record engine
    always_comb begin
        rec_cmd = '0;
        if (mode == looper_pkg::REC) begin
            rec_cmd.start = rec_sel.valid;
            rec_cmd.stop  = buttons.stop;
            rec_cmd.addr  = rec_addr;
        end
    end

    // play engine, one shot pad over optional backing track
    always_comb begin
        play_cmd = '0;
        if (mode == looper_pkg::PLAY) begin
            play_cmd.start        = pad_hit;
            play_cmd.stop         = buttons.stop;
            play_cmd.addr         = pad_addr;
            play_cmd.backing      = backing.valid;
            play_cmd.backing_addr = backing_addr;
            play_cmd.speed        = knobs.speed;
        end
    end

    // mix engine
    always_comb begin
        mix_cmd = '0;
        if (mode == looper_pkg::MIX) begin
            // start held for the whole mode
            mix_cmd.start = 1'b1;
            mix_cmd.stop  = buttons.stop;
            if (pad_hit) begin
                mix_cmd.num[looper_pkg::NUM_SLOTS-1:0] = pad_mask;
            end
            // top bit flags the backing track
            mix_cmd.num[looper_pkg::NUM_SLOTS] = backing.valid;
            mix_cmd.backing_addr               = backing_addr;
            mix_cmd.loop                       = knobs.loop_mask;
        end
    end

endmodule

// ==== rtl/looper_control_top.sv ====
`timescale 1ns/1ps

module looper_control_top #(
    parameter int CHUNK_SHIFT = looper_pkg::DEF_CHUNK_SHIFT
) (
    input  logic                             i_clk,
    input  logic                             i_rst,
    // key is unconnected, kept for pin compatibility
    input  logic [3:0]                       key,
    input  logic [17:0]                      sw,
    input  logic [13:0]                      gpio,
    input  logic                             rec_done,
    input  logic                             play_done,
    input  logic                             mix_done,
    output logic [3:0]                       control_mode,
    // record engine
    output logic                             rec_start,
    output logic                             rec_stop,
    output logic [looper_pkg::ADDR_W-1:0]    rec_addr,
    // play engine
    output logic                             play_start,
    output logic                             play_stop,
    output logic [looper_pkg::ADDR_W-1:0]    play_addr,
    output logic                             play_record,
    output logic [looper_pkg::ADDR_W-1:0]    play_backing_addr,
    output logic [1:0]                       play_speed,
    // mix engine
    output logic                             mix_start,
    output logic                             mix_stop,
    output logic [looper_pkg::NUM_SLOTS:0]   mix_num,
    output logic [looper_pkg::ADDR_W-1:0]    mix_backing_addr,
    output logic [looper_pkg::NUM_SLOTS-1:0] mix_loop
);

    looper_pkg::buttons_t  buttons;
    looper_pkg::slot_sel_t pad;
    looper_pkg::slot_sel_t rec_sel;
    looper_pkg::knobs_t    knobs;
    looper_pkg::mode_e     mode;
    logic                  page;
    looper_pkg::slot_sel_t backing;
    looper_pkg::rec_cmd_t  rec_cmd;
    looper_pkg::play_cmd_t play_cmd;
    looper_pkg::mix_cmd_t  mix_cmd;

    panel_decoder u_panel (
        .gpio    (gpio),
        .sw      (sw),
        .buttons (buttons),
        .pad     (pad),
        .rec_sel (rec_sel),
        .knobs   (knobs)
    );

    mode_controller u_mode (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .buttons   (buttons),
        .rec_sel   (rec_sel),
        .rec_done  (rec_done),
        .play_done (play_done),
        .mix_done  (mix_done),
        .mode      (mode),
        .page      (page),
        .backing   (backing)
    );

    command_builder #(
        .CHUNK_SHIFT (CHUNK_SHIFT)
    ) u_cmd (
        .mode     (mode),
        .page     (page),
        .backing  (backing),
        .buttons  (buttons),
        .pad      (pad),
        .rec_sel  (rec_sel),
        .knobs    (knobs),
        .rec_cmd  (rec_cmd),
        .play_cmd (play_cmd),
        .mix_cmd  (mix_cmd)
    );

    assign control_mode = mode;

    // flatten command structs onto engine pins
    assign rec_start         = rec_cmd.start;
    assign rec_stop          = rec_cmd.stop;
    assign rec_addr          = rec_cmd.addr;
    assign play_start        = play_cmd.start;
    assign play_stop         = play_cmd.stop;
    assign play_addr         = play_cmd.addr;
    assign play_record       = play_cmd.backing;
    assign play_backing_addr = play_cmd.backing_addr;
    assign play_speed        = play_cmd.speed;
    assign mix_start         = mix_cmd.start;
    assign mix_stop          = mix_cmd.stop;
    assign mix_num           = mix_cmd.num;
    assign mix_backing_addr  = mix_cmd.backing_addr;
    assign mix_loop          = mix_cmd.loop;

endmodule

// ==== bench/tb_looper_control.sv ====
`timescale 1ns/1ps

module tb_looper_control;

    // one table row with done bits as {rec, play, mix}
    typedef struct packed {
        logic [13:0] gpio;
        logic [17:0] sw;
        logic [2:0]  done;
    } row_t;

    localparam int SHIFT = 18;
    localparam logic [3:0] M_IDLE = 4'd0;
    localparam logic [3:0] M_REC  = 4'd1;
    localparam logic [3:0] M_PLAY = 4'd2;
    localparam logic [3:0] M_MIX  = 4'd3;
    // button bits on gpio
    localparam logic [13:0] G_REC  = 14'h0800;
    localparam logic [13:0] G_PLAY = 14'h0400;
    localparam logic [13:0] G_MIX  = 14'h0200;
    localparam logic [13:0] G_STOP = 14'h0100;
    localparam logic [2:0]  D_NONE = 3'b000;
    localparam logic [2:0]  D_REC  = 3'b100;
    localparam logic [2:0]  D_PLAY = 3'b010;
    localparam logic [2:0]  D_MIX  = 3'b001;

    logic        i_clk;
    logic        i_rst;
    logic [3:0]  key;
    logic [17:0] sw;
    logic [13:0] gpio;
    logic        rec_done;
    logic        play_done;
    logic        mix_done;
    logic [3:0]  control_mode;
    logic        rec_start;
    logic        rec_stop;
    logic [22:0] rec_addr;
    logic        play_start;
    logic        play_stop;
    logic [22:0] play_addr;
    logic        play_record;
    logic [22:0] play_backing_addr;
    logic [1:0]  play_speed;
    logic        mix_start;
    logic        mix_stop;
    logic [16:0] mix_num;
    logic [22:0] mix_backing_addr;
    logic [15:0] mix_loop;

    row_t rows[$];
    // reference state
    logic [3:0] m_mode;
    logic       m_page;
    logic       m_bvalid;
    logic [3:0] m_bidx;
    int         wait_cnt;

    looper_control_top dut0 (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .key               (key),
        .sw                (sw),
        .gpio              (gpio),
        .rec_done          (rec_done),
        .play_done         (play_done),
        .mix_done          (mix_done),
        .control_mode      (control_mode),
        .rec_start         (rec_start),
        .rec_stop          (rec_stop),
        .rec_addr          (rec_addr),
        .play_start        (play_start),
        .play_stop         (play_stop),
        .play_addr         (play_addr),
        .play_record       (play_record),
        .play_backing_addr (play_backing_addr),
        .play_speed        (play_speed),
        .mix_start         (mix_start),
        .mix_stop          (mix_stop),
        .mix_num           (mix_num),
        .mix_backing_addr  (mix_backing_addr),
        .mix_loop          (mix_loop)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // reset held 8 cycles and released on a falling edge
    initial begin
        i_rst = 1'b1;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // gpio bit of pad k
    // pad 7 sits on gpio 13
    function automatic logic [13:0] pad_bit(input int k);
        return (k == 7) ? 14'h2000 : (14'h0001 << k);
    endfunction

    // {valid, index} when exactly one bit is raised
    function automatic logic [4:0] single_bit(input logic [15:0] bits);
        logic [4:0] res;
        res = 5'b0;
        if ($countones(bits) == 1) begin
            for (int i = 0; i < 16; i++) begin
                if (bits[i]) res = {1'b1, 4'(i)};
            end
        end
        return res;
    endfunction

    task automatic add_row(input logic [13:0] g, input logic [17:0] s, input logic [2:0] d);
        rows.push_back({g, s, d});
    endtask

    task automatic fill_table;
        add_row(14'h0000, 18'h00008, D_NONE);
        add_row(G_STOP, 18'h00000, D_NONE);
        // all three buttons with mix winning
        add_row(G_REC | G_PLAY | G_MIX, 18'h00000, D_NONE);
        add_row(14'h0000, 18'h00000, D_MIX);
        // record into slot 5 and later slot 9
        add_row(G_REC, 18'h00020, D_NONE);
        add_row(14'h0000, 18'h00020, D_NONE);
        add_row(G_STOP, 18'h00200, D_NONE);
        add_row(14'h0000, 18'h00204, D_NONE);
        add_row(14'h0000, 18'h00001, D_REC);
        // backing on slot 3 then play
        add_row(G_PLAY, 18'h00008, D_NONE);
        add_row(pad_bit(3), 18'h10000, D_NONE);
        add_row(pad_bit(2), 18'h18000, D_NONE);
        // page flip with stop held too
        add_row(G_REC | G_STOP, 18'h00000, D_NONE);
        add_row(pad_bit(0), 18'h00000, D_NONE);
        add_row(pad_bit(0) | pad_bit(1), 18'h00000, D_NONE);
        add_row(pad_bit(7), 18'h08000, D_NONE);
        add_row(14'h0000, 18'h00000, D_PLAY);
        // mix over backing slot 12 with page still 1
        add_row(G_MIX, 18'h01000, D_NONE);
        add_row(pad_bit(4), 18'h0a5a5, D_NONE);
        add_row(pad_bit(5) | G_STOP, 18'h3ffff, D_NONE);
        add_row(G_REC, 18'h00000, D_NONE);
        add_row(pad_bit(4), 18'h01234, D_NONE);
        add_row(14'h0000, 18'h00000, D_MIX);
        // two switches clear the backing slot
        add_row(14'h0000, 18'h00011, D_NONE);
        add_row(G_MIX, 18'h00000, D_NONE);
        // slot 0 pad is not suppressed without a valid backing slot
        add_row(pad_bit(0), 18'h0ffff, D_NONE);
        add_row(14'h0000, 18'h00000, D_MIX);
        add_row(14'h0000, 18'h00000, D_NONE);
    endtask

    // drive on falling edge and check just before the rising edge
    // model steps afterwards
    task automatic apply_row(input row_t r);
        logic        rb;
        logic        pb;
        logic        mb;
        logic        sb;
        logic [4:0]  pad;
        logic [4:0]  rsel;
        logic [3:0]  slot;
        logic        go;
        logic        in_rec;
        logic        in_play;
        logic        in_mix;
        logic [22:0] baddr;
        logic [22:0] e_rec_addr;
        logic [22:0] e_play_addr;
        logic [16:0] e_num;
        gpio = r.gpio;
        sw   = r.sw;
        {rec_done, play_done, mix_done} = r.done;
        #15;
        rb      = r.gpio[11];
        pb      = r.gpio[10];
        mb      = r.gpio[9];
        sb      = r.gpio[8];
        pad     = single_bit({8'h00, r.gpio[13], r.gpio[6:0]});
        rsel    = single_bit(r.sw[15:0]);
        slot    = {m_page, pad[2:0]};
        // suppressed only on a valid backing slot match
        go      = pad[4] && !(m_bvalid && (m_bidx == slot));
        in_rec  = (m_mode == M_REC);
        in_play = (m_mode == M_PLAY);
        in_mix  = (m_mode == M_MIX);
        baddr   = m_bvalid ? (23'(m_bidx) << SHIFT) : 23'd0;
        e_rec_addr  = (in_rec && rsel[4]) ? (23'(rsel[3:0]) << SHIFT) : 23'd0;
        e_play_addr = (in_play && pad[4]) ? (23'(slot) << SHIFT) : 23'd0;
        e_num = 17'd0;
        if (in_mix) begin
            if (go) e_num[slot] = 1'b1;
            e_num[16] = m_bvalid;
        end
        check("control_mode", control_mode, m_mode);
        check("rec_start", rec_start, in_rec & rsel[4]);
        check("rec_stop", rec_stop, in_rec & sb);
        check("rec_addr", rec_addr, e_rec_addr);
        check("play_start", play_start, in_play & go);
        check("play_stop", play_stop, in_play & sb);
        check("play_addr", play_addr, e_play_addr);
        check("play_record", play_record, in_play & m_bvalid);
        check("play_backing_addr", play_backing_addr, in_play ? baddr : 23'd0);
        check("play_speed", play_speed, in_play ? r.sw[16:15] : 2'd0);
        check("mix_start", mix_start, in_mix);
        check("mix_stop", mix_stop, in_mix & sb);
        check("mix_num", mix_num, e_num);
        check("mix_backing_addr", mix_backing_addr, in_mix ? baddr : 23'd0);
        check("mix_loop", mix_loop, in_mix ? r.sw[15:0] : 16'd0);
        // next state as the rising edge will see it
        if (m_mode == M_IDLE) begin
            m_bvalid = rsel[4];
            m_bidx   = rsel[4] ? rsel[3:0] : 4'd0;
            if (mb) m_mode = M_MIX;
            else if (pb) m_mode = M_PLAY;
            else if (rb) m_mode = M_REC;
        end else if (in_rec) begin
            if (r.done[2]) m_mode = M_IDLE;
        end else begin
            if (rb) m_page = ~m_page;
            if ((in_play && r.done[1]) || (in_mix && r.done[0])) m_mode = M_IDLE;
        end
    endtask

    initial begin
        key       = 4'h0;
        sw        = 18'h0;
        gpio      = 14'h0;
        rec_done  = 1'b0;
        play_done = 1'b0;
        mix_done  = 1'b0;
        m_mode    = M_IDLE;
        m_page    = 1'b0;
        m_bvalid  = 1'b0;
        m_bidx    = 4'd0;
        fill_table();
        wait_cnt = 0;
        while (i_rst !== 1'b0) begin
            @(posedge i_clk);
            wait_cnt++;
            if (wait_cnt > 50) begin
                $display("timeout: reset was never released");
                $display("TEST FAILED");
                $fatal(1, "reset timeout");
            end
        end
        foreach (rows[i]) begin
            @(negedge i_clk);
            apply_row(rows[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/looper_pkg.sv
rtl/panel_decoder.sv
rtl/mode_controller.sv
rtl/command_builder.sv
rtl/looper_control_top.sv
bench/tb_looper_control.sv
